/* source/cache_pkg.sv */
package cache_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W   = 32;  // Processor byte address
    localparam int DATA_W   = 32;  // One word per line
    localparam int OFFSET_W = 2;   // Byte offset inside a word
    localparam int NUM_WAYS = 2;   // Fixed, LRU is one bit per set

    // Vector types
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [1:0]        resp_t;
    typedef logic              way_t;   // Way number, 0 or 1

    // AXI-Lite response code, the cache never reports an error
    localparam resp_t RESP_OKAY = 2'b00;

    // ----------------------------------------------------------------------
    // Controller states
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE      = 3'd0,  // Take a request, reads first
        LOOKUP    = 3'd1,  // Array results arrive
        WB_SEND   = 3'd2,  // Dirty victim out on mem AW/W
        WB_RESP   = 3'd3,  // Wait for mem B
        FILL_REQ  = 3'd4,  // Refill address on mem AR
        FILL_DATA = 3'd5,  // Wait for mem R
        RESPOND   = 3'd6   // Hold R or B until accepted
    } cache_state_e;

endpackage

/* source/cache_sram.sv */
`timescale 1ns/1ps

module cache_sram #(
    parameter  int DEPTH = 64,
    parameter  int WIDTH = 32,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic [AW-1:0]    addr,
    input  logic             re,        // Read strobe
    input  logic             we,        // Write strobe
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out   // Holds until the next read
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Single port, registered read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data_in;
        end
        if (re) begin
            data_out <= mem[addr];  // One cycle latency
        end
    end

endmodule

/* source/cache_array_if.sv */
`timescale 1ns/1ps

interface cache_array_if import cache_pkg::*; #(
    parameter int INDEX_W = 6,
    parameter int TAG_W   = 24
) ();

    // Controller to arrays
    logic [INDEX_W-1:0] set;        // Set for lookup and writes
    logic               lookup_en;  // Read every array at set
    logic               wr_en;      // Fill or update one way
    way_t               wr_way;
    logic [TAG_W-1:0]   wr_tag;     // Also the tag looked up
    word_t              wr_data;
    logic               wr_dirty;
    logic               lru_en;     // Update the LRU bit
    way_t               lru_way;    // Way just used

    // Arrays to controller, valid the cycle after lookup_en
    logic               hit;
    way_t               hit_way;
    word_t              hit_data;
    way_t               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    word_t              victim_data;

    modport ctrl (
        output set, lookup_en, wr_en, wr_way, wr_tag, wr_data, wr_dirty, lru_en, lru_way,
        input  hit, hit_way, hit_data, victim_way, victim_dirty, victim_tag, victim_data
    );

    modport arrays (
        input  set, lookup_en, wr_en, wr_way, wr_tag, wr_data, wr_dirty, lru_en, lru_way,
        output hit, hit_way, hit_data, victim_way, victim_dirty, victim_tag, victim_data
    );

endinterface

/* source/cache_arrays.sv */
`timescale 1ns/1ps

module cache_arrays import cache_pkg::*; #(
    parameter  int NUM_SETS = 64,
    localparam int INDEX_W  = $clog2(NUM_SETS)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] sweep_set,     // Set being cleared
    input  logic               sweep_active,
    cache_array_if.arrays      arr
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic [INDEX_W-1:0] ram_addr;
    logic [TAG_W-1:0]   lookup_tag;   // Tag of the last lookup
    logic               lookup_q;     // RAM outputs belong to a lookup

    logic [TAG_W-1:0]   tag_q   [NUM_WAYS];
    word_t              data_q  [NUM_WAYS];
    logic               valid_q [NUM_WAYS];
    logic               dirty_q [NUM_WAYS];
    logic               way_we  [NUM_WAYS];
    logic               way_hit [NUM_WAYS];
    logic               lru_q;         // Way to evict next

    // The sweep owns the address port until every set is cleared
    assign ram_addr = sweep_active ? sweep_set : arr.set;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= arr.lookup_en;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.lookup_en) begin
            lookup_tag <= arr.wr_tag;
        end
    end

    // ----------------------------------------------------------------------
    // Per-way storage, data and tag plus the two state bits
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        assign way_we[w]  = arr.wr_en && (arr.wr_way == way_t'(w));
        assign way_hit[w] = valid_q[w] && (tag_q[w] == lookup_tag);

        cache_sram #(.DEPTH(NUM_SETS), .WIDTH(DATA_W)) data_ram (
            .clk(clk), .addr(ram_addr), .re(arr.lookup_en), .we(way_we[w]),
            .data_in(arr.wr_data), .data_out(data_q[w])
        );
        cache_sram #(.DEPTH(NUM_SETS), .WIDTH(TAG_W)) tag_ram (
            .clk(clk), .addr(ram_addr), .re(arr.lookup_en), .we(way_we[w]),
            .data_in(arr.wr_tag), .data_out(tag_q[w])
        );
        // Valid is set by any write, cleared only by the sweep
        cache_sram #(.DEPTH(NUM_SETS), .WIDTH(1)) valid_ram (
            .clk(clk), .addr(ram_addr), .re(arr.lookup_en),
            .we(way_we[w] || sweep_active),
            .data_in(!sweep_active), .data_out(valid_q[w])
        );
        cache_sram #(.DEPTH(NUM_SETS), .WIDTH(1)) dirty_ram (
            .clk(clk), .addr(ram_addr), .re(arr.lookup_en),
            .we(way_we[w] || sweep_active),
            .data_in(arr.wr_dirty && !sweep_active), .data_out(dirty_q[w])
        );
    end

    // LRU bit names the victim, a write points it at the other way
    cache_sram #(.DEPTH(NUM_SETS), .WIDTH(1)) lru_ram (
        .clk(clk), .addr(ram_addr), .re(arr.lookup_en),
        .we(arr.lru_en || sweep_active),
        .data_in(!arr.lru_way && !sweep_active), .data_out(lru_q)
    );

    // ----------------------------------------------------------------------
    // Hit and victim
    // ----------------------------------------------------------------------
    assign arr.hit      = lookup_q && (way_hit[0] || way_hit[1]);
    assign arr.hit_way  = way_hit[1];              // Tags never match in both ways
    assign arr.hit_data = data_q[arr.hit_way];

    // Sweep leaves LRU at 0 and every fill moves it off the new line,
    // so an empty way is picked before any valid one
    assign arr.victim_way   = lru_q;
    assign arr.victim_dirty = dirty_q[lru_q];     // Dirty implies valid
    assign arr.victim_tag   = tag_q[lru_q];
    assign arr.victim_data  = data_q[lru_q];

endmodule

/* source/cache_init_sweep.sv */
`timescale 1ns/1ps

module cache_init_sweep #(
    parameter  int NUM_SETS = 64,
    localparam int INDEX_W  = $clog2(NUM_SETS)
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [INDEX_W-1:0] sweep_set,     // One set per cycle
    output logic               sweep_active   // High during the sweep
);

    localparam logic [INDEX_W-1:0] LAST_SET = INDEX_W'(NUM_SETS - 1);

    // Held at set 0 and active during reset, so the first cycle
    // out of reset already clears set 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_set    <= '0;
            sweep_active <= 1'b1;
        end else if (sweep_active) begin
            sweep_set <= sweep_set + 1'b1;        // Wraps back to 0
            if (sweep_set == LAST_SET) begin
                sweep_active <= 1'b0;             // Done until next reset
            end
        end
    end

endmodule

/* source/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

module cache_ctrl_fsm import cache_pkg::*; #(
    parameter int NUM_SETS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sweep_active,   // Arrays busy clearing
    cache_array_if.ctrl arr,

    // Processor side
    input  addr_t       awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  word_t       wdata,
    input  logic        wvalid,
    output logic        wready,
    output resp_t       bresp,
    output logic        bvalid,
    input  logic        bready,
    input  addr_t       araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output resp_t       rresp,
    output logic        rvalid,
    input  logic        rready,

    // Next memory level
    output addr_t       mem_awaddr,
    output logic        mem_awvalid,
    input  logic        mem_awready,
    output word_t       mem_wdata,
    output logic        mem_wvalid,
    input  logic        mem_wready,
    input  logic        mem_bvalid,
    output logic        mem_bready,
    output addr_t       mem_araddr,
    output logic        mem_arvalid,
    input  logic        mem_arready,
    input  word_t       mem_rdata,
    input  logic        mem_rvalid,
    output logic        mem_rready
);

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    cache_state_e state, next_state;

    addr_t req_addr;    // Latched request
    word_t req_data;
    logic  req_write;   // 1 for a write
    word_t resp_data;   // Word returned on R
    way_t  fill_way;    // Victim way, refilled later
    addr_t cur_addr;    // Address the arrays see
    logic  rd_req;
    logic  wr_req;
    logic  fill_beat;   // mem R transfer
    logic  aw_done;     // mem AW already taken
    logic  w_done;
    logic  aw_ok;
    logic  w_ok;

    // ----------------------------------------------------------------------
    // Request acceptance
    // ----------------------------------------------------------------------
    assign arready = (state == IDLE) && !sweep_active;
    assign awready = arready && !arvalid;      // Reads win
    assign wready  = awready;                  // AW and W only together
    assign rd_req  = arvalid && arready;
    assign wr_req  = awvalid && wvalid && awready;

    // Lookup uses the incoming address in IDLE, the latched one after
    assign cur_addr = (state != IDLE) ? req_addr :
                      arvalid         ? araddr   : awaddr;

    assign fill_beat = (state == FILL_DATA) && mem_rvalid;
    assign aw_ok     = aw_done || mem_awready;
    assign w_ok      = w_done || mem_wready;

    // ----------------------------------------------------------------------
    // Array control
    // ----------------------------------------------------------------------
    assign arr.set       = cur_addr[INDEX_W+OFFSET_W-1:OFFSET_W];
    assign arr.wr_tag    = cur_addr[ADDR_W-1 -: TAG_W];
    assign arr.lookup_en = rd_req || wr_req;
    assign arr.wr_en     = ((state == LOOKUP) && arr.hit && req_write) || fill_beat;
    assign arr.wr_way    = (state == LOOKUP) ? arr.hit_way : fill_way;
    assign arr.wr_data   = (fill_beat && !req_write) ? mem_rdata : req_data;
    assign arr.wr_dirty  = req_write;               // Clean refill on reads
    assign arr.lru_en    = ((state == LOOKUP) && arr.hit) || fill_beat;
    assign arr.lru_way   = arr.wr_way;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (rd_req || wr_req) next_state = LOOKUP;
            LOOKUP: begin
                if (arr.hit)               next_state = RESPOND;
                else if (arr.victim_dirty) next_state = WB_SEND;
                else                       next_state = FILL_REQ;
            end
            WB_SEND:   if (aw_ok && w_ok) next_state = WB_RESP;
            WB_RESP:   if (mem_bvalid) next_state = FILL_REQ;   // Code ignored
            FILL_REQ:  if (mem_arready) next_state = FILL_DATA;
            FILL_DATA: if (mem_rvalid) next_state = RESPOND;
            RESPOND:   if (req_write ? bready : rready) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state   <= next_state;
            aw_done <= (state == WB_SEND) && aw_ok;   // Cleared once past WB_SEND
            w_done  <= (state == WB_SEND) && w_ok;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (rd_req || wr_req) begin
            req_addr  <= cur_addr;
            req_data  <= wdata;
            req_write <= !rd_req;
        end
        if (state == LOOKUP) begin
            fill_way   <= arr.victim_way;
            resp_data  <= arr.hit_data;
            // Victim address rebuilt from its tag and the same set
            mem_awaddr <= {arr.victim_tag, arr.set, {OFFSET_W{1'b0}}};
            mem_wdata  <= arr.victim_data;
        end
        if (fill_beat) begin
            resp_data <= mem_rdata;
        end
    end

    // ----------------------------------------------------------------------
    // Channel outputs
    // ----------------------------------------------------------------------
    assign mem_awvalid = (state == WB_SEND) && !aw_done;
    assign mem_wvalid  = (state == WB_SEND) && !w_done;
    assign mem_bready  = (state == WB_RESP);
    assign mem_arvalid = (state == FILL_REQ);
    assign mem_araddr  = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // Word aligned
    assign mem_rready  = (state == FILL_DATA);

    assign rvalid = (state == RESPOND) && !req_write;
    assign bvalid = (state == RESPOND) && req_write;
    assign rdata  = resp_data;
    assign rresp  = RESP_OKAY;
    assign bresp  = RESP_OKAY;

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
    parameter int NUM_SETS = 64   // Power of two
) (
    input  logic  clk,
    input  logic  rst_n,

    // ----------------------------------------------------------------------
    // Processor AXI-Lite, subordinate
    // ----------------------------------------------------------------------
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,

    // ----------------------------------------------------------------------
    // Memory AXI-Lite, manager
    // ----------------------------------------------------------------------
    output addr_t mem_awaddr,
    output logic  mem_awvalid,
    input  logic  mem_awready,
    output word_t mem_wdata,
    output logic  mem_wvalid,
    input  logic  mem_wready,
    input  logic  mem_bvalid,
    output logic  mem_bready,
    output addr_t mem_araddr,
    output logic  mem_arvalid,
    input  logic  mem_arready,
    input  word_t mem_rdata,
    input  logic  mem_rvalid,
    output logic  mem_rready
);

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    logic [INDEX_W-1:0] sweep_set;
    logic               sweep_active;

    cache_array_if #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) arr_if ();

    // Clears the state bits of every set after reset
    cache_init_sweep #(.NUM_SETS(NUM_SETS)) sweep_i (
        .clk(clk), .rst_n(rst_n), .sweep_set(sweep_set), .sweep_active(sweep_active)
    );

    cache_arrays #(.NUM_SETS(NUM_SETS)) arrays_i (
        .clk(clk), .rst_n(rst_n), .sweep_set(sweep_set), .sweep_active(sweep_active),
        .arr(arr_if.arrays)
    );

    cache_ctrl_fsm #(.NUM_SETS(NUM_SETS)) ctrl_i (
        .clk(clk), .rst_n(rst_n), .sweep_active(sweep_active), .arr(arr_if.ctrl),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .mem_awaddr(mem_awaddr), .mem_awvalid(mem_awvalid), .mem_awready(mem_awready),
        .mem_wdata(mem_wdata), .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
        .mem_bvalid(mem_bvalid), .mem_bready(mem_bready),
        .mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
    );

endmodule

/* dv/axil_mem_model.sv */
`timescale 1ns/1ps

module axil_mem_model import cache_pkg::*; (
    input  logic  clk,
    input  addr_t mem_awaddr,
    input  logic  mem_awvalid,
    output logic  mem_awready,
    input  word_t mem_wdata,
    input  logic  mem_wvalid,
    output logic  mem_wready,
    output logic  mem_bvalid,
    input  logic  mem_bready,
    input  addr_t mem_araddr,
    input  logic  mem_arvalid,
    output logic  mem_arready,
    output word_t mem_rdata,
    output logic  mem_rvalid,
    input  logic  mem_rready
);

    integer seed = 44;
    word_t  mem [addr_t];      // Only words written so far
    addr_t  log_addr [$];      // Every accepted write, in order
    word_t  log_data [$];
    int     rd_count = 0;      // AR transfers seen

    // Untouched words read back as the inverted address
    function automatic word_t read_word(input addr_t a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    // ----------------------------------------------------------------------
    // One transfer at a time, everything driven on the falling edge
    // ----------------------------------------------------------------------
    initial begin
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(negedge clk);
            if (mem_awvalid && mem_wvalid) begin
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                mem_awready = 1'b1;             // AW and W taken together
                mem_wready  = 1'b1;
                @(negedge clk);
                mem_awready = 1'b0;
                mem_wready  = 1'b0;
                mem[mem_awaddr] = mem_wdata;
                log_addr.push_back(mem_awaddr);
                log_data.push_back(mem_wdata);
                mem_bvalid = 1'b1;
                while (!mem_bready) @(negedge clk);
                @(negedge clk);                  // B taken at the edge between
                mem_bvalid = 1'b0;
            end else if (mem_arvalid) begin
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                mem_arready = 1'b1;
                @(negedge clk);
                mem_arready = 1'b0;
                rd_count++;
                mem_rdata  = read_word(mem_araddr);  // Address still held
                mem_rvalid = 1'b1;
                while (!mem_rready) @(negedge clk);
                @(negedge clk);
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule

/* dv/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int NUM_SETS = 16;
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int TMO      = 200;               // Cycles per wait

    logic  clk, rst_n;
    addr_t awaddr, araddr, mem_awaddr, mem_araddr;
    word_t wdata, rdata, mem_wdata, mem_rdata;
    resp_t bresp, rresp;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;
    logic  mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    logic  mem_arvalid, mem_arready, mem_rvalid, mem_rready;

    integer seed = 44;
    int     errors = 0;
    int     ntests = 0;
    int     npass  = 0;

    // Reference cache state and next-level memory image
    logic [TAG_W-1:0] m_tag   [NUM_SETS][2];
    word_t            m_data  [NUM_SETS][2];
    bit               m_valid [NUM_SETS][2];
    bit               m_dirty [NUM_SETS][2];
    bit               m_lru   [NUM_SETS];        // Way evicted next
    word_t            shadow  [addr_t];

    // Values handed to the compare process
    event  resp_ev;
    bit    c_wr, c_wb;
    word_t c_exp, c_got, c_wb_data;
    resp_t c_resp;
    addr_t c_wb_addr;
    int    c_log0;

    cache_top #(.NUM_SETS(NUM_SETS)) dut_i (.*);

    axil_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Reference model of one access
    // ----------------------------------------------------------------------
    function automatic void ref_access(input bit wr, input addr_t a, input word_t d,
                                       output word_t exp_data, output bit wb,
                                       output addr_t wb_addr, output word_t wb_data);
        int               s;
        int               w;
        bit               found;
        logic [TAG_W-1:0] t;
        s  = a[INDEX_W+OFFSET_W-1:OFFSET_W];
        t  = a[ADDR_W-1 -: TAG_W];
        wb = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        found   = 1'b0;
        w       = 0;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                found = 1'b1;
                w = i;
            end
        end
        if (!found) begin
            w = m_lru[s];
            if (m_valid[s][w] && m_dirty[s][w]) begin   // Dirty victim goes out first
                wb      = 1'b1;
                wb_addr = {m_tag[s][w], INDEX_W'(s), 2'b00};
                wb_data = m_data[s][w];
                shadow[wb_addr] = wb_data;
            end
            m_tag[s][w]   = t;
            m_valid[s][w] = 1'b1;
            m_dirty[s][w] = 1'b0;
            m_data[s][w]  = shadow.exists(a) ? shadow[a] : ~a;
        end
        if (wr) begin
            m_data[s][w]  = d;
            m_dirty[s][w] = 1'b1;
        end
        m_lru[s] = (w == 0);                         // Point away from the used way
        exp_data = wr ? '0 : m_data[s][w];
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Starts and ends on a falling edge; lat counts edges from handshake to response
    task automatic do_access(input bit wr, input addr_t a, input word_t d,
                             input bit stall, output int lat);
        int n;
        lat = -1;
        ref_access(wr, a, d, c_exp, c_wb, c_wb_addr, c_wb_data);
        c_wr   = wr;
        c_log0 = mem_i.log_addr.size();
        if (wr) begin
            awaddr  = a;
            wdata   = d;
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end else begin
            araddr  = a;
            arvalid = 1'b1;
        end
        n = 0;
        while (!(wr ? awready : arready) && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (n >= TMO) begin
            report_timeout("request never accepted");
            return;
        end
        @(negedge clk);                              // Handshake edge passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        n = 0;
        while (!(wr ? bvalid : rvalid) && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (n >= TMO) begin
            report_timeout("no response from the cache");
            return;
        end
        lat = n;
        if (stall) repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        rready = !wr;
        bready = wr;
        c_got  = rdata;                              // Held until accepted
        c_resp = wr ? bresp : rresp;
        -> resp_ev;
        @(negedge clk);
        rready = 1'b0;
        bready = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Compare process
    // ----------------------------------------------------------------------
    always @(resp_ev) begin
        if (!c_wr) begin
            assert (c_got == c_exp) else begin
                $display("ERR %0t rdata exp=%h got=%h", $time, c_exp, c_got);
                errors++;
            end
        end
        assert (c_resp == 2'b00) else begin
            $display("ERR %0t %s exp=%h got=%h", $time, c_wr ? "bresp" : "rresp",
                     2'b00, c_resp);
            errors++;
        end
        // Memory side quiet while the response is held
        assert (!mem_awvalid && !mem_wvalid && !mem_arvalid &&
                !mem_bready && !mem_rready) else begin
            $display("A memory channel is active while the response is held");
            errors++;
        end
        assert (mem_i.log_addr.size() == c_log0 + int'(c_wb)) else begin
            $display("ERR %0t mem_write_count exp=%0d got=%0d", $time,
                     c_log0 + int'(c_wb), mem_i.log_addr.size());
            errors++;
        end
        if (c_wb && mem_i.log_addr.size() > c_log0) begin
            assert (mem_i.log_addr[c_log0] == c_wb_addr) else begin
                $display("ERR %0t mem_awaddr exp=%h got=%h", $time,
                         c_wb_addr, mem_i.log_addr[c_log0]);
                errors++;
            end
            assert (mem_i.log_data[c_log0] == c_wb_data) else begin
                $display("ERR %0t mem_wdata exp=%h got=%h", $time,
                         c_wb_data, mem_i.log_data[c_log0]);
                errors++;
            end
        end
    end

    task automatic end_test(input string name, input int err0);
        ntests++;
        if (errors == err0) begin
            npass++;
            $display("Test %-12s ok", name);
        end else begin
            $display("Test %-12s failed with %0d errors", name, errors - err0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int    err0, n, lat, r0, w0;
        addr_t a;
        word_t d;
        bit    wr;
        rst_n = 1'b0;
        {awaddr, araddr, wdata} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        repeat (16) @(negedge clk);

        // Reset and the set-clearing sweep
        err0 = errors;
        assert (!rvalid && !bvalid && !mem_awvalid && !mem_wvalid && !mem_arvalid) else begin
            $display("A valid output is high during reset");
            errors++;
        end
        rst_n = 1'b1;
        n = 0;
        while (!arready && n < TMO) begin
            n++;
            @(negedge clk);
        end
        if (n >= TMO) begin
            report_timeout("arready never rose after reset");
        end else begin
            assert (n == NUM_SETS) else begin
                $display("ERR %0t arready_low_cycles exp=%0d got=%0d", $time, NUM_SETS, n);
                errors++;
            end
        end
        assert (awready && wready) else begin
            $display("Write channels not ready after the sweep");
            errors++;
        end
        end_test("reset", err0);

        // Clean miss, then hit with no memory traffic
        err0 = errors;
        r0 = mem_i.rd_count;
        do_access(1'b0, 32'h0000_1104, '0, 1'b0, lat);
        assert (mem_i.rd_count == r0 + 1) else begin
            $display("ERR %0t mem_ar_count exp=%0d got=%0d", $time, r0 + 1, mem_i.rd_count);
            errors++;
        end
        r0 = mem_i.rd_count;
        do_access(1'b0, 32'h0000_1104, '0, 1'b0, lat);
        assert (lat == 1 && mem_i.rd_count == r0) else begin
            $display("ERR %0t hit_latency exp=1 got=%0d (mem reads %0d)", $time, lat,
                     mem_i.rd_count - r0);
            errors++;
        end
        end_test("read_hit", err0);

        // Write-allocate miss, write hit, read back
        err0 = errors;
        do_access(1'b1, 32'h0000_2208, 32'hcafe_0001, 1'b0, lat);
        do_access(1'b1, 32'h0000_2208, 32'hcafe_0002, 1'b0, lat);
        do_access(1'b0, 32'h0000_2208, '0, 1'b0, lat);
        end_test("write_read", err0);

        // Two dirty lines in set 5, third tag evicts the LRU one
        err0 = errors;
        do_access(1'b1, 32'h1000_0014, 32'h1111_1111, 1'b0, lat);
        do_access(1'b1, 32'h2000_0014, 32'h2222_2222, 1'b0, lat);
        w0 = mem_i.log_addr.size();
        do_access(1'b0, 32'h3000_0014, '0, 1'b0, lat);
        assert (mem_i.log_addr.size() == w0 + 1) else begin
            $display("ERR %0t eviction_writes exp=1 got=%0d", $time,
                     mem_i.log_addr.size() - w0);
            errors++;
        end
        do_access(1'b0, 32'h1000_0014, '0, 1'b0, lat);
        end_test("eviction", err0);

        // Random traffic over four sets and four tags
        err0 = errors;
        for (int i = 0; i < 200; i++) begin
            a  = (($unsigned($random(seed)) % 4) << 24) | (($unsigned($random(seed)) % 4) << 2);
            d  = $random(seed);
            wr = $random(seed);
            do_access(wr, a, d, 1'b1, lat);
        end
        end_test("random", err0);

        $display("Summary: %0d tests, %0d passed, %0d errors", ntests, npass, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* cache.f */
source/cache_pkg.sv
source/cache_sram.sv
source/cache_array_if.sv
source/cache_arrays.sv
source/cache_init_sweep.sv
source/cache_ctrl_fsm.sv
source/cache_top.sv
dv/axil_mem_model.sv
dv/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - source/cache_pkg.sv
  - source/cache_sram.sv
  - source/cache_array_if.sv
  - source/cache_arrays.sv
  - source/cache_init_sweep.sv
  - source/cache_ctrl_fsm.sv
  - source/cache_top.sv
  - target: test
    files:
      - dv/axil_mem_model.sv
      - dv/cache_tb.sv
